// ==== logic/pg_pkg.sv ====
package pg_pkg;

    ////////////////////
    // field widths
    localparam int KC_W    = 7;
    localparam int KF_W    = 6;
    localparam int PITCH_W = KC_W + KF_W;
    localparam int PMS_W   = 3;
    localparam int DT2_W   = 2;
    localparam int LFP_W   = 8;

    // integer part on top, 6-bit fraction below
    typedef logic [PITCH_W-1:0] pitch_t;

    ////////////////////
    // pitch limits
    // note 126 is the last legal code (note 127 falls outside a group)
    localparam pitch_t PITCH_MAX = {7'd126, 6'd63};
    localparam pitch_t PITCH_MIN = '0;

    // detune-2 offsets, indexed by DT2
    localparam logic [KC_W-1:0] DT2_INT_OFS [4] = '{7'd0, 7'd8, 7'd9, 7'd12};
    localparam logic [KF_W-1:0] DT2_FRAC_OFS [4] = '{6'd0, 6'd0, 6'd52, 6'd32};

    ////////////////////
    // stage payloads
    typedef struct packed {
        logic [KC_W-1:0]  kc;
        logic [KF_W-1:0]  kf;
        logic [PMS_W-1:0] pms;
        logic [DT2_W-1:0] dt2;
        logic [LFP_W-1:0] ex_lfp;
        // set when the deviation has to be subtracted
        logic             lfp_sign;
    } key_stage_t;

    typedef struct packed {
        pitch_t           pitch;
        logic [DT2_W-1:0] dt2;
    } pitch_stage_t;

endpackage

// ==== logic/pg_stage_if.sv ====
`timescale 1ns/1ns

interface pg_stage_if #(
    parameter type PAYLOAD_T = logic
);

    // payload only meaningful while valid is high
    logic     valid;
    PAYLOAD_T data;

    modport src (
        output valid,
        output data
    );

    modport dst (
        input valid,
        input data
    );

endinterface

// ==== logic/pg_key_input.sv ====
`timescale 1ns/1ns

module pg_key_input
    import pg_pkg::*;
#(
    parameter bit PIPE_VALID_RESET = 1'b0
) (
    input  logic              i_EMUCLK,
    input  logic              i_rst_n,
    input  logic              i_cen,
    input  logic              i_valid,
    input  logic [KC_W-1:0]   i_kc,
    input  logic [KF_W-1:0]   i_kf,
    input  logic [PMS_W-1:0]  i_pms,
    input  logic [DT2_W-1:0]  i_dt2,
    input  logic [LFP_W-1:0]  i_lfp,
    pg_stage_if.src           o_key
);

    logic             pms_max;
    logic [2:0]       lfp_w0;
    logic [2:0]       lfp_w1;
    logic             lfp_w2;
    logic [3:0]       lfp_wsum;
    logic [LFP_W-1:0] ex_lfp;
    key_stage_t       key_d;
    key_stage_t       key_q;
    logic             valid_q;

    ////////////////////
    // extended lfp
    assign pms_max = (i_pms == 3'd7);

    // weighted sum of the top magnitude bits
    assign lfp_w0 = pms_max ? i_lfp[6:4] : {1'b0, i_lfp[6:5]};
    assign lfp_w1 = pms_max ? {2'b00, i_lfp[6]} : 3'b000;
    assign lfp_w2 = pms_max ? ((i_lfp[6] & i_lfp[5]) | (i_lfp[5] & i_lfp[4])) :
                    (i_pms == 3'd6) ? (i_lfp[6] & i_lfp[5]) : 1'b0;

    assign lfp_wsum = {1'b0, lfp_w0} + {1'b0, lfp_w1} + {3'b000, lfp_w2};

    // pms 7 keeps one more weighted bit and one less raw bit
    assign ex_lfp = pms_max ? {lfp_wsum, i_lfp[3:0]} : {lfp_wsum[2:0], i_lfp[4:0]};

    always_comb begin
        key_d.kc       = i_kc;
        key_d.kf       = i_kf;
        key_d.pms      = i_pms;
        key_d.dt2      = i_dt2;
        key_d.ex_lfp   = ex_lfp;
        // negative lfp only matters with vibrato enabled
        key_d.lfp_sign = (i_pms != '0) & i_lfp[LFP_W-1];
    end

    ////////////////////
    // registers
    always_ff @(posedge i_EMUCLK) begin
        if (!i_rst_n) begin
            valid_q <= PIPE_VALID_RESET;
        end else if (i_cen) begin
            valid_q <= i_valid;
        end
    end

    always_ff @(posedge i_EMUCLK) begin
        if (i_cen) begin
            key_q <= key_d;
        end
    end

    assign o_key.valid = valid_q;
    assign o_key.data  = key_q;

endmodule

// ==== logic/pg_vibrato_mod.sv ====
`timescale 1ns/1ns

module pg_vibrato_mod
    import pg_pkg::*;
#(
    parameter bit PIPE_VALID_RESET = 1'b0
) (
    input  logic     i_EMUCLK,
    input  logic     i_rst_n,
    input  logic     i_cen,
    pg_stage_if.dst  i_key,
    pg_stage_if.src  o_pitch
);

    key_stage_t       key_in;
    logic             neg;

    // stage 1
    logic [PITCH_W-1:0] dev;
    logic [KF_W:0]      frac_sum;
    logic [KC_W:0]      int_sum;
    logic [2:0]         ng_sum;
    pitch_t             s1_pitch;
    logic               s1_ovfl;
    logic               s1_ng_noadd;
    logic               s1_ng_ovfl;
    logic               s1_sign;
    logic [DT2_W-1:0]   s1_dt2;
    logic               s1_valid;

    // stage 2
    logic               add1;
    logic               sub1;
    logic [KC_W:0]      int_adj;
    pitch_t             s2_pitch;
    logic               s2_rovfl;
    logic               s2_ovfl;
    logic               s2_sub1;
    logic               s2_sign;
    logic [DT2_W-1:0]   s2_dt2;
    logic               s2_valid;

    // stage 3
    pitch_t             sat_pitch;
    pitch_stage_t       pitch_q;
    logic               valid_q;

    assign key_in = i_key.data;
    assign neg    = key_in.lfp_sign;

    ////////////////////
    // stage 1 deviation and add
    always_comb begin
        case (key_in.pms)
            3'd0: dev = '0;
            3'd1: dev = {11'b0, key_in.ex_lfp[6:5]};
            3'd2: dev = {10'b0, key_in.ex_lfp[6:4]};
            3'd3: dev = {9'b0, key_in.ex_lfp[6:3]};
            3'd4: dev = {8'b0, key_in.ex_lfp[6:2]};
            3'd5: dev = {7'b0, key_in.ex_lfp[6:1]};
            3'd6: dev = {4'b0, key_in.ex_lfp, 1'b0};
            3'd7: dev = {3'b0, key_in.ex_lfp, 2'b0};
        endcase
    end

    // two's complement subtract when the lfp is negative
    assign frac_sum = {1'b0, key_in.kf} + {1'b0, dev[KF_W-1:0] ^ {KF_W{neg}}} +
                      {{KF_W{1'b0}}, neg};
    assign int_sum  = {1'b0, key_in.kc} + {1'b0, dev[PITCH_W-1:KF_W] ^ {KC_W{neg}}} +
                      {{KC_W{1'b0}}, frac_sum[KF_W]};

    // same add on the note-group bits only, to see the group carry
    assign ng_sum = {1'b0, key_in.kc[1:0]} + {1'b0, dev[KF_W+1:KF_W] ^ {2{neg}}} +
                    {2'b00, frac_sum[KF_W]};

    ////////////////////
    // stage 2 note-group repair
    // positive: skip over note 3 of a group
    assign add1 = ((s1_pitch[KF_W+1:KF_W] == 2'd3) | s1_ng_ovfl) & ~s1_sign;
    // negative: borrow out of the group steps one more down
    assign sub1 = s1_sign & ~s1_ng_noadd & ~s1_ng_ovfl;

    assign int_adj = {1'b0, s1_pitch[PITCH_W-1:KF_W]} + {1'b0, {KC_W{sub1}}} +
                     {{KC_W{1'b0}}, add1};

    ////////////////////
    // stage 3 saturation
    always_comb begin
        sat_pitch = s2_pitch;
        if (!s2_sign) begin
            if (s2_ovfl || s2_rovfl) begin
                sat_pitch = PITCH_MAX;
            end
        end else if (!s2_ovfl || (s2_sub1 && !s2_rovfl)) begin
            // borrow out of the add or out of the -1 step
            sat_pitch = PITCH_MIN;
        end
    end

    always_ff @(posedge i_EMUCLK) begin
        if (!i_rst_n) begin
            s1_valid <= PIPE_VALID_RESET;
            s2_valid <= PIPE_VALID_RESET;
            valid_q  <= PIPE_VALID_RESET;
        end else if (i_cen) begin
            s1_valid <= i_key.valid;
            s2_valid <= s1_valid;
            valid_q  <= s2_valid;
        end
    end

    always_ff @(posedge i_EMUCLK) begin
        if (i_cen) begin
            s1_pitch    <= {int_sum[KC_W-1:0], frac_sum[KF_W-1:0]};
            s1_ovfl     <= int_sum[KC_W];
            s1_ng_noadd <= ~(dev[KF_W] | dev[KF_W+1]);
            s1_ng_ovfl  <= ng_sum[2];
            s1_sign     <= neg;
            s1_dt2      <= key_in.dt2;

            s2_pitch    <= {int_adj[KC_W-1:0], s1_pitch[KF_W-1:0]};
            s2_rovfl    <= int_adj[KC_W];
            s2_ovfl     <= s1_ovfl;
            s2_sub1     <= sub1;
            s2_sign     <= s1_sign;
            s2_dt2      <= s1_dt2;

            pitch_q.pitch <= sat_pitch;
            pitch_q.dt2   <= s2_dt2;
        end
    end

    assign o_pitch.valid = valid_q;
    assign o_pitch.data  = pitch_q;

endmodule

// ==== logic/pg_detune2.sv ====
`timescale 1ns/1ns

module pg_detune2
    import pg_pkg::*;
#(
    parameter bit PIPE_VALID_RESET = 1'b0
) (
    input  logic     i_EMUCLK,
    input  logic     i_rst_n,
    input  logic     i_cen,
    pg_stage_if.dst  i_pitch,
    output logic     o_valid,
    output pitch_t   o_pitch
);

    pitch_stage_t     p_in;

    // stage 4
    logic [KF_W:0]    frac_sum;
    logic [KF_W:0]    s4_frac;
    logic [KC_W-1:0]  s4_int;
    logic [DT2_W-1:0] s4_dt2;
    logic             s4_valid;

    // stage 5
    logic [1:0]       ng_carry;
    logic [KC_W:0]    int_sum;
    logic [KC_W:0]    s5_int;
    logic [KF_W-1:0]  s5_frac;
    logic             s5_valid;

    // stage 6
    pitch_t           pitch_q;
    logic             valid_q;

    assign p_in = i_pitch.data;

    ////////////////////
    // stage 4 fraction offset
    assign frac_sum = {1'b0, p_in.pitch[KF_W-1:0]} + {1'b0, DT2_FRAC_OFS[p_in.dt2]};

    ////////////////////
    // stage 5 integer offset
    // carry of 2 jumps over the unused note at the top of a group
    always_comb begin
        if (s4_dt2 == 2'd2) begin
            // dt2=2 table is shifted by one note
            if (s4_frac[KF_W]) begin
                ng_carry = (s4_int[1:0] == 2'd0) ? 2'd1 : 2'd2;
            end else begin
                ng_carry = s4_int[1] ? 2'd1 : 2'd0;
            end
        end else begin
            if (s4_frac[KF_W]) begin
                ng_carry = s4_int[1] ? 2'd2 : 2'd1;
            end else begin
                ng_carry = 2'd0;
            end
        end
    end

    assign int_sum = {1'b0, s4_int} + {1'b0, DT2_INT_OFS[s4_dt2]} +
                     {{(KC_W-1){1'b0}}, ng_carry};

    ////////////////////
    // registers
    always_ff @(posedge i_EMUCLK) begin
        if (!i_rst_n) begin
            s4_valid <= PIPE_VALID_RESET;
            s5_valid <= PIPE_VALID_RESET;
            valid_q  <= PIPE_VALID_RESET;
        end else if (i_cen) begin
            s4_valid <= i_pitch.valid;
            s5_valid <= s4_valid;
            valid_q  <= s5_valid;
        end
    end

    always_ff @(posedge i_EMUCLK) begin
        if (i_cen) begin
            s4_frac <= frac_sum;
            s4_int  <= p_in.pitch[PITCH_W-1:KF_W];
            s4_dt2  <= p_in.dt2;

            // fraction carry already folded into ng_carry
            s5_int  <= int_sum;
            s5_frac <= s4_frac[KF_W-1:0];

            // stage 6 final clamp
            pitch_q <= s5_int[KC_W] ? PITCH_MAX : {s5_int[KC_W-1:0], s5_frac};
        end
    end

    assign o_valid = valid_q;
    assign o_pitch = pitch_q;

endmodule

// ==== logic/pg_pitch_top.sv ====
`timescale 1ns/1ns

module pg_pitch_top
    import pg_pkg::*;
#(
    parameter bit PIPE_VALID_RESET = 1'b0
) (
    input  logic              i_EMUCLK,
    input  logic              i_rst_n,
    // phi1 enable
    input  logic              i_cen,

    input  logic              i_valid,
    input  logic [KC_W-1:0]   i_kc,
    input  logic [KF_W-1:0]   i_kf,
    input  logic [PMS_W-1:0]  i_pms,
    input  logic [DT2_W-1:0]  i_dt2,
    input  logic [LFP_W-1:0]  i_lfp,

    output logic              o_valid,
    output pitch_t            o_pitch
);

    ////////////////////
    // stage links
    pg_stage_if #(.PAYLOAD_T(key_stage_t))   key_if ();
    pg_stage_if #(.PAYLOAD_T(pitch_stage_t)) pitch_if ();

    // 1 cycle: key registers and extended lfp
    pg_key_input #(
        .PIPE_VALID_RESET (PIPE_VALID_RESET)
    ) u_key_input (
        .i_EMUCLK (i_EMUCLK),
        .i_rst_n  (i_rst_n),
        .i_cen    (i_cen),
        .i_valid  (i_valid),
        .i_kc     (i_kc),
        .i_kf     (i_kf),
        .i_pms    (i_pms),
        .i_dt2    (i_dt2),
        .i_lfp    (i_lfp),
        .o_key    (key_if.src)
    );

    // 3 cycles: vibrato add, group repair, saturation
    pg_vibrato_mod #(
        .PIPE_VALID_RESET (PIPE_VALID_RESET)
    ) u_vibrato_mod (
        .i_EMUCLK (i_EMUCLK),
        .i_rst_n  (i_rst_n),
        .i_cen    (i_cen),
        .i_key    (key_if.dst),
        .o_pitch  (pitch_if.src)
    );

    // 3 cycles: detune-2 and final clamp
    pg_detune2 #(
        .PIPE_VALID_RESET (PIPE_VALID_RESET)
    ) u_detune2 (
        .i_EMUCLK (i_EMUCLK),
        .i_rst_n  (i_rst_n),
        .i_cen    (i_cen),
        .i_pitch  (pitch_if.dst),
        .o_valid  (o_valid),
        .o_pitch  (o_pitch)
    );

endmodule

// ==== tests/pg_pitch_asserts.sv ====
`timescale 1ns/1ns

module pg_pitch_asserts
    import pg_pkg::*;
(
    input logic   i_EMUCLK,
    input logic   i_rst_n,
    input logic   i_cen,
    input logic   o_valid,
    input pitch_t o_pitch
);

    ////////////////////
    // output side
    // valid bits leave reset low
    a_valid_low_after_reset: assert property (
        @(posedge i_EMUCLK) !i_rst_n |=> !o_valid
    ) else $error("o_valid high in the cycle after reset");

    // a disabled edge freezes the pipeline
    a_valid_held_without_cen: assert property (
        @(posedge i_EMUCLK) disable iff (!i_rst_n) !i_cen |=> $stable(o_valid)
    ) else $error("o_valid changed on an edge with i_cen low");

    a_pitch_in_range: assert property (
        @(posedge i_EMUCLK) disable iff (!i_rst_n) o_valid |-> (o_pitch <= PITCH_MAX)
    ) else $error("o_pitch above the saturation ceiling");

endmodule

bind pg_pitch_top pg_pitch_asserts u_asserts (
    .i_EMUCLK (i_EMUCLK),
    .i_rst_n  (i_rst_n),
    .i_cen    (i_cen),
    .o_valid  (o_valid),
    .o_pitch  (o_pitch)
);

// ==== tests/tb_pg_pitch.sv ====
`timescale 1ns/1ns

module tb_pg_pitch;
    import pg_pkg::*;

    localparam int NUM_TESTS   = 35;
    localparam int COLS        = 6;
    localparam int LATENCY     = 7;
    // room for enable gaps on top of 8 cycles per test and the pipeline fill
    localparam int CYCLE_LIMIT = (8 * NUM_TESTS + LATENCY) * 4;

    logic              i_EMUCLK;
    logic              i_rst_n;
    logic              i_cen;
    logic              i_valid;
    logic [KC_W-1:0]   i_kc;
    logic [KF_W-1:0]   i_kf;
    logic [PMS_W-1:0]  i_pms;
    logic [DT2_W-1:0]  i_dt2;
    logic [LFP_W-1:0]  i_lfp;
    logic              o_valid;
    pitch_t            o_pitch;

    logic [15:0] vec_mem [NUM_TESTS*COLS];
    pitch_t      drv_exp;
    pitch_t      exp_q [$];
    int          entry_q [$];
    int          en_cnt;
    int          cycle_cnt;
    int          n_checked;
    int          seed;
    logic        prev_cen;
    logic        prev_rst_n;
    logic        prev_valid;
    pitch_t      prev_pitch;

    pg_pitch_top #(
        .PIPE_VALID_RESET (1'b0)
    ) dut (
        .i_EMUCLK (i_EMUCLK),
        .i_rst_n  (i_rst_n),
        .i_cen    (i_cen),
        .i_valid  (i_valid),
        .i_kc     (i_kc),
        .i_kf     (i_kf),
        .i_pms    (i_pms),
        .i_dt2    (i_dt2),
        .i_lfp    (i_lfp),
        .o_valid  (o_valid),
        .o_pitch  (o_pitch)
    );

    initial begin
        i_EMUCLK = 1'b0;
        forever #10 i_EMUCLK = ~i_EMUCLK;
    end

    task automatic abort_run();
        $display("SIMULATION FAILED");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] expected);
        if (got !== expected) begin
            $display("ERROR %0t: %s got %0h expected %0h", $time, name, got, expected);
            abort_run();
        end
    endtask

    // one vector per enabled edge and held over disabled edges
    task automatic drive_pass(input bit gaps);
        int   idx;
        int   rnd;
        logic cen_bit;
        idx = 0;
        while (idx < NUM_TESTS) begin
            @(posedge i_EMUCLK);
            rnd = $random(seed);
            cen_bit = gaps ? rnd[0] : 1'b1;
            i_cen   <= cen_bit;
            i_valid <= 1'b1;
            i_kc    <= vec_mem[idx*COLS+0][KC_W-1:0];
            i_kf    <= vec_mem[idx*COLS+1][KF_W-1:0];
            i_pms   <= vec_mem[idx*COLS+2][PMS_W-1:0];
            i_dt2   <= vec_mem[idx*COLS+3][DT2_W-1:0];
            i_lfp   <= vec_mem[idx*COLS+4][LFP_W-1:0];
            drv_exp <= vec_mem[idx*COLS+5][PITCH_W-1:0];
            if (cen_bit) begin
                idx++;
            end
        end
    endtask

    ////////////////////
    // monitor and scoreboard
    always @(posedge i_EMUCLK) begin
        cycle_cnt++;
        if (cycle_cnt > CYCLE_LIMIT) begin
            $display("timeout after %0d cycles, %0d results checked", cycle_cnt, n_checked);
            abort_run();
        end
        if (!prev_rst_n) begin
            check_value("o_valid", o_valid, 1'b0);
        end
        if (i_rst_n) begin
            if (!prev_cen) begin
                check_value("o_valid", o_valid, prev_valid);
                check_value("o_pitch", o_pitch, prev_pitch);
            end
            if (i_cen) begin
                if (o_valid) begin
                    if (exp_q.size() == 0) begin
                        $display("o_valid high with no sample in the pipeline");
                        abort_run();
                    end
                    check_value("o_pitch", o_pitch, exp_q.pop_front());
                    check_value("latency", en_cnt - entry_q.pop_front(), LATENCY);
                    n_checked++;
                end
                if (i_valid) begin
                    exp_q.push_back(drv_exp);
                    entry_q.push_back(en_cnt);
                end
                en_cnt++;
            end
        end
        prev_cen   = i_cen | ~i_rst_n;
        prev_rst_n = i_rst_n;
        prev_valid = o_valid;
        prev_pitch = o_pitch;
    end

    initial begin
        seed       = 48;
        cycle_cnt  = 0;
        en_cnt     = 0;
        n_checked  = 0;
        prev_cen   = 1'b1;
        prev_rst_n = 1'b1;
        prev_valid = 1'b0;
        prev_pitch = '0;
        i_rst_n    = 1'b0;
        i_cen      = 1'b1;
        i_valid    = 1'b0;
        i_kc       = '0;
        i_kf       = '0;
        i_pms      = '0;
        i_dt2      = '0;
        i_lfp      = '0;
        drv_exp    = '0;
        $readmemh("tests/pg_pitch_tests.txt", vec_mem);
        if ($isunknown(vec_mem[NUM_TESTS*COLS-1])) begin
            $display("test vector file missing or shorter than %0d lines", NUM_TESTS);
            abort_run();
        end
        repeat (2) @(posedge i_EMUCLK);
        i_rst_n <= 1'b1;
        // back to back with the enable held high
        drive_pass(1'b0);
        // same vectors again with random enable gaps
        drive_pass(1'b1);
        @(posedge i_EMUCLK);
        i_valid <= 1'b0;
        i_cen   <= 1'b1;
        wait (n_checked == 2 * NUM_TESTS);
        // idle edges so a stray o_valid still reaches the scoreboard
        repeat (4) @(posedge i_EMUCLK);
        $display("SIMULATION PASSED");
        $finish;
    end

endmodule

// ==== tb.f ====
logic/pg_pkg.sv
logic/pg_stage_if.sv
logic/pg_key_input.sv
logic/pg_vibrato_mod.sv
logic/pg_detune2.sv
logic/pg_pitch_top.sv
tests/pg_pitch_asserts.sv
tests/tb_pg_pitch.sv

// ==== Bender.yml ====
package:
  name: pg_pitch

sources:
  - logic/pg_pkg.sv
  - logic/pg_stage_if.sv
  - logic/pg_key_input.sv
  - logic/pg_vibrato_mod.sv
  - logic/pg_detune2.sv
  - logic/pg_pitch_top.sv
  - target: test
    files:
      - tests/pg_pitch_asserts.sv
      - tests/tb_pg_pitch.sv

// ==== tests/pg_pitch_tests.txt ====
// columns: kc kf pms dt2 lfp expected_pitch (hex)
// lfp bit 7 is the sign, expected pitch is {int[6:0], frac[5:0]}
00 00 0 0 00 0000
10 05 0 0 00 0405
7e 3f 0 0 00 1fbf
56 20 0 0 ff 15a0
13 00 0 0 00 0500
10 00 1 0 60 0403
20 3c 2 0 7f 0843
08 30 4 0 7c 024f
02 01 5 0 7e 0100
10 00 6 0 60 0500
11 00 6 0 25 048a
20 10 7 0 7f 0a8c
12 05 7 0 20 0545
10 08 1 0 e0 0405
14 20 6 0 a5 0496
16 20 6 0 a5 0556
40 00 7 0 ff 0d44
05 03 2 0 f0 013c
31 00 5 0 82 0c3f
7e 30 7 0 7f 1fbf
7d 00 5 0 7e 1f7f
7e 3f 1 0 20 1fbf
00 05 7 0 ff 0000
00 20 6 0 a5 0000
10 05 0 1 00 0605
10 05 0 3 00 0725
11 30 0 3 00 0790
12 30 0 3 00 0810
10 05 0 2 00 0679
12 05 0 2 00 0739
14 10 0 2 00 0784
15 10 0 2 00 0804
7e 30 0 3 00 1fbf
7a 00 0 1 00 1fbf
02 01 5 3 7e 0420
